// ==== common/rtc_pkg.sv ====
package rtc_pkg;

  localparam int NUM_FIELDS = 7;
  localparam int NUM_BTNS   = 4;

  // button bit positions
  localparam int BTN_INC   = 0;
  localparam int BTN_DEC   = 1;
  localparam int BTN_LEFT  = 2;
  localparam int BTN_RIGHT = 3;

  localparam int DEBOUNCE_BITS_DEF = 16;
  localparam int TICK_DIV_DEF      = 25_000_000;

  // legal BCD range per field, index 0 is seconds
  localparam logic [NUM_FIELDS-1:0][7:0] field_min = {
    8'h00, 8'h01, 8'h01, 8'h01, 8'h00, 8'h00, 8'h00
  };
  localparam logic [NUM_FIELDS-1:0][7:0] field_max = {
    8'h99, 8'h12, 8'h31, 8'h07, 8'h23, 8'h59, 8'h59
  };

  localparam logic [7:0] CENTURY_BCD = 8'h20;
  localparam logic [7:0] MARKER_BYTE = 8'h11;

  typedef struct packed {
    logic [7:0] spare;
    logic [7:0] year;
    logic [7:0] month;
    logic [7:0] date;
    logic [7:0] weekday;
    logic [7:0] hour;
    logic [7:0] minute;
    logic [7:0] second;
  } rtc_fields_t;

  // byte view for the write port, field view for the carry chain
  typedef union packed {
    logic [7:0][7:0] bytes;
    rtc_fields_t     f;
  } rtc_time_u;

  // every field starts at its minimum
  localparam rtc_time_u RTC_RESET = {8'h00, field_min};

  typedef struct packed {
    logic [2:0] addr;
    logic [7:0] data;
  } rtc_wr_t;

  typedef struct packed {
    logic [7:0][7:0] marker;
    logic [7:0][7:0] datetime;
  } display_frame_t;

endpackage

// ==== src/btn_debounce.sv ====
module btn_debounce
  import rtc_pkg::*;
#(
  parameter int DEBOUNCE_BITS = DEBOUNCE_BITS_DEF
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [NUM_BTNS-1:0] btn,
  output logic [NUM_BTNS-1:0] rise
);

  logic [NUM_BTNS-1:0]      sync;
  logic [NUM_BTNS-1:0]      level;
  logic [DEBOUNCE_BITS-1:0] cnt [NUM_BTNS];

  always_ff @(posedge clk) begin
    if (rst) begin
      sync  <= '0;
      level <= '0;
      rise  <= '0;
      for (int i = 0; i < NUM_BTNS; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      sync <= btn;
      rise <= '0;
      for (int i = 0; i < NUM_BTNS; i++) begin
        if (sync[i] == level[i]) begin
          // input agrees with level, restart the window
          cnt[i] <= '0;
        end else if (&cnt[i]) begin
          // stable for the full window
          level[i] <= sync[i];
          rise[i]  <= sync[i];
          cnt[i]   <= '0;
        end else begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== editor/bcd_step.sv ====
module bcd_step
  import rtc_pkg::*;
(
  input  logic [2:0] field,
  input  logic [7:0] value,
  input  logic       down,
  output logic [7:0] result
);

  logic [7:0] lo;
  logic [7:0] hi;
  logic       valid_field;
  logic       in_range;
  logic [7:0] bcd_inc;
  logic [7:0] bcd_dec;

  assign valid_field = int'(field) < NUM_FIELDS;

  // field 7 has no range, treat it as a fixed zero
  assign lo = valid_field ? field_min[field] : 8'h00;
  assign hi = valid_field ? field_max[field] : 8'h00;

  // valid BCD compares like plain binary
  assign in_range = (value[3:0] <= 4'd9) && (value >= lo) && (value <= hi);

  // digit carry and borrow
  assign bcd_inc = (value[3:0] == 4'd9) ? {value[7:4] + 4'd1, 4'h0} : value + 8'd1;
  assign bcd_dec = (value[3:0] == 4'd0) ? {value[7:4] - 4'd1, 4'h9} : value - 8'd1;

  always_comb begin
    if (!in_range) begin
      result = lo;
    end else if (down) begin
      result = (value == lo) ? hi : bcd_dec;
    end else begin
      result = (value == hi) ? lo : bcd_inc;
    end
  end

endmodule

// ==== editor/rtc_edit_ctrl.sv ====
module rtc_edit_ctrl
  import rtc_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NUM_BTNS-1:0] rise,
  input  rtc_time_u           datetime,
  input  logic                wr_ready,
  output logic [2:0]          cursor,
  output logic                wr_valid,
  output rtc_wr_t             wr
);

  typedef enum logic {
    ST_IDLE,
    ST_PEND
  } state_t;

  state_t     state;
  logic       edit_req;
  logic [7:0] cur_byte;
  logic [7:0] stepped;

  assign edit_req = rise[BTN_INC] || rise[BTN_DEC];
  assign cur_byte = datetime.bytes[cursor];
  assign wr_valid = (state == ST_PEND);

  // decrement wins if both edit buttons rise together
  bcd_step u_step (
    .field  (cursor),
    .value  (cur_byte),
    .down   (rise[BTN_DEC]),
    .result (stepped)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      cursor <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (edit_req) begin
            state <= ST_PEND;
          end else if (rise[BTN_LEFT]) begin
            // byte 0 sits at the right of the display, so left moves up
            cursor <= (int'(cursor) == NUM_FIELDS - 1) ? 3'd0 : cursor + 3'd1;
          end else if (rise[BTN_RIGHT]) begin
            cursor <= (cursor == 3'd0) ? 3'(NUM_FIELDS - 1) : cursor - 3'd1;
          end
        end
        ST_PEND: begin
          // buttons ignored until the keeper takes the write
          if (wr_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request payload, frozen while pending
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && edit_req) begin
      wr.addr <= cursor;
      wr.data <= stepped;
    end
  end

endmodule

// ==== rtc/rtc_time_keeper.sv ====
module rtc_time_keeper
  import rtc_pkg::*;
#(
  parameter int TICK_DIV = TICK_DIV_DEF
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_valid,
  input  rtc_wr_t   wr,
  output logic      wr_ready,
  output logic      tick,
  output rtc_time_u datetime
);

  logic [$clog2(TICK_DIV)-1:0] presc;
  rtc_time_u                   adv;
  logic                        c_min;
  logic                        c_hour;
  logic                        c_day;
  logic                        c_mon;
  logic                        c_year;

  // one BCD unit up, wrapping inside the field range
  function automatic logic [7:0] roll(input logic [7:0] v, input int idx);
    logic [7:0] up;
    up = (v[3:0] == 4'd9) ? {v[7:4] + 4'd1, 4'h0} : v + 8'd1;
    return (v == field_max[idx]) ? field_min[idx] : up;
  endfunction

  // tick owns the cycle, writes wait
  assign wr_ready = !tick;

  always_ff @(posedge clk) begin
    if (rst) begin
      presc <= '0;
      tick  <= 1'b0;
    end else if (int'(presc) == TICK_DIV - 1) begin
      presc <= '0;
      tick  <= 1'b1;
    end else begin
      presc <= presc + 1'b1;
      tick  <= 1'b0;
    end
  end

  // carry chain
  assign c_min  = datetime.f.second == field_max[0];
  assign c_hour = c_min && datetime.f.minute == field_max[1];
  assign c_day  = c_hour && datetime.f.hour == field_max[2];
  assign c_mon  = c_day && datetime.f.date == field_max[4];
  assign c_year = c_mon && datetime.f.month == field_max[5];

  always_comb begin
    adv          = datetime;
    adv.f.second = roll(datetime.f.second, 0);
    if (c_min) begin
      adv.f.minute = roll(datetime.f.minute, 1);
    end
    if (c_hour) begin
      adv.f.hour = roll(datetime.f.hour, 2);
    end
    // weekday runs alongside the date
    if (c_day) begin
      adv.f.weekday = roll(datetime.f.weekday, 3);
      adv.f.date    = roll(datetime.f.date, 4);
    end
    if (c_mon) begin
      adv.f.month = roll(datetime.f.month, 5);
    end
    if (c_year) begin
      adv.f.year = roll(datetime.f.year, 6);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      datetime <= RTC_RESET;
    end else if (tick) begin
      datetime <= adv;
    end else if (wr_valid && wr_ready && int'(wr.addr) < NUM_FIELDS) begin
      // spare byte stays zero
      datetime.bytes[wr.addr] <= wr.data;
    end
  end

endmodule

// ==== src/display_frame.sv ====
module display_frame
  import rtc_pkg::*;
(
  input  logic           clk,
  input  logic           rst,
  input  logic           tick,
  input  logic           wr_fire,
  input  logic [2:0]     cursor,
  input  rtc_time_u      datetime,
  output display_frame_t frame
);

  logic            upd;
  logic [7:0][7:0] marker_nxt;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      marker_nxt[i] = (int'(cursor) == i) ? MARKER_BYTE : 8'h00;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      upd            <= 1'b0;
      frame.datetime <= {CENTURY_BCD, RTC_RESET.bytes[6:0]};
      frame.marker   <= '0;
      frame.marker[0] <= MARKER_BYTE;
    end else begin
      // datetime settles one cycle after tick or write
      upd <= tick || wr_fire;
      if (upd) begin
        frame.datetime <= {CENTURY_BCD, datetime.bytes[6:0]};
      end
      frame.marker <= marker_nxt;
    end
  end

endmodule

// ==== src/rtc_console_top.sv ====
module rtc_console_top
  import rtc_pkg::*;
#(
  parameter int DEBOUNCE_BITS = DEBOUNCE_BITS_DEF,
  parameter int TICK_DIV      = TICK_DIV_DEF
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [NUM_BTNS-1:0] btn,
  output rtc_time_u           datetime,
  output display_frame_t      frame,
  output logic [2:0]          cursor
);

  logic [NUM_BTNS-1:0] btn_rise;
  logic                wr_valid;
  logic                wr_ready;
  logic                wr_fire;
  logic                tick;
  rtc_wr_t             wr;

  assign wr_fire = wr_valid & wr_ready;

  btn_debounce #(
    .DEBOUNCE_BITS (DEBOUNCE_BITS)
  ) u_debounce (
    .clk  (clk),
    .rst  (rst),
    .btn  (btn),
    .rise (btn_rise)
  );

  rtc_edit_ctrl u_edit (
    .clk      (clk),
    .rst      (rst),
    .rise     (btn_rise),
    .datetime (datetime),
    .wr_ready (wr_ready),
    .cursor   (cursor),
    .wr_valid (wr_valid),
    .wr       (wr)
  );

  rtc_time_keeper #(
    .TICK_DIV (TICK_DIV)
  ) u_keeper (
    .clk      (clk),
    .rst      (rst),
    .wr_valid (wr_valid),
    .wr       (wr),
    .wr_ready (wr_ready),
    .tick     (tick),
    .datetime (datetime)
  );

  display_frame u_frame (
    .clk      (clk),
    .rst      (rst),
    .tick     (tick),
    .wr_fire  (wr_fire),
    .cursor   (cursor),
    .datetime (datetime),
    .frame    (frame)
  );

endmodule

// ==== bench/rtc_console_tb.sv ====
module rtc_console_tb
  import rtc_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS      = 20;
  localparam int DEB_BITS    = 3;
  localparam int TICK_CYCLES = 64;
  // cycles after a tick edge when datetime and frame have settled
  localparam int SETTLE      = 8;

  // tick periods per test with a full minute for each wait on a given second
  localparam int RESET_PERIODS  = 1;
  localparam int COUNT_PERIODS  = 61 + 5 + 60 + 1;
  localparam int EDIT_PERIODS   = 2 + 60 + 60 + 2 + 1 + 2 + 2;
  localparam int CURSOR_PERIODS = 4;
  localparam int GLITCH_PERIODS = 5;
  localparam int WATCHDOG_NS    = (RESET_PERIODS + COUNT_PERIODS + EDIT_PERIODS
                                   + CURSOR_PERIODS + GLITCH_PERIODS + 20)
                                  * TICK_CYCLES * CLK_NS;

  logic                clk = 1'b0;
  logic                rst;
  logic [NUM_BTNS-1:0] btn;
  rtc_time_u           datetime;
  display_frame_t      frame;
  logic [2:0]          cursor;

  int              edges;
  int              applied;
  int              cur_model;
  logic [7:0][7:0] model;
  logic [15:0]     lfsr = 16'd47735;

  rtc_console_top #(
    .DEBOUNCE_BITS (DEB_BITS),
    .TICK_DIV      (TICK_CYCLES)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .btn      (btn),
    .datetime (datetime),
    .frame    (frame),
    .cursor   (cursor)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // edges since reset release
  // tick n lands on edge 64n
  always @(posedge clk) begin
    if (rst) begin
      edges <= 0;
    end else begin
      edges <= edges + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $fatal(1);
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // x16 + x14 + x13 + x11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic int bcd_to_int(input logic [7:0] b);
    return int'(b[7:4]) * 10 + int'(b[3:0]);
  endfunction

  // one unit inside the field range with wrap at both ends
  function automatic logic [7:0] step_field(input int f, input logic [7:0] v, input logic down);
    int lo;
    int hi;
    int x;
    lo = bcd_to_int(field_min[f]);
    hi = bcd_to_int(field_max[f]);
    x  = bcd_to_int(v);
    if (down) begin
      x = (x == lo) ? hi : x - 1;
    end else begin
      x = (x == hi) ? lo : x + 1;
    end
    return {4'(x / 10), 4'(x % 10)};
  endfunction

  function automatic logic [7:0][7:0] advance_second(input logic [7:0][7:0] t);
    logic [7:0][7:0] n;
    logic            carry;
    n     = t;
    carry = 1'b1;
    for (int f = 0; f < NUM_FIELDS; f++) begin
      // weekday only moves along with the date
      if (carry && f != 3) begin
        if (f == 4) begin
          n[3] = step_field(3, t[3], 1'b0);
        end
        n[f]  = step_field(f, t[f], 1'b0);
        carry = (t[f] == field_max[f]);
      end
    end
    return n;
  endfunction

  function automatic logic [63:0] marker_for(input int c);
    logic [7:0][7:0] m;
    for (int i = 0; i < 8; i++) begin
      m[i] = (i == c) ? 8'h11 : 8'h00;
    end
    return m;
  endfunction

  task automatic compare_model();
    check("datetime", datetime.bytes, model);
    check("frame.datetime", frame.datetime, {8'h20, model[6:0]});
    check("frame.marker", frame.marker, marker_for(cur_model));
    check("cursor", cursor, cur_model);
  endtask

  // next settled point after a tick with the model caught up to the elapsed ticks
  task automatic next_point();
    int n;
    do begin
      @(negedge clk);
    end while ((edges % TICK_CYCLES) != SETTLE);
    n = edges / TICK_CYCLES;
    while (applied < n) begin
      model = advance_second(model);
      applied++;
    end
    compare_model();
  endtask

  task automatic wait_second(input logic [7:0] v);
    do begin
      next_point();
    end while (model[0] != v);
  endtask

  task automatic press(input int b);
    @(posedge clk);
    btn[b] <= 1'b1;
    repeat (16) @(posedge clk);
    btn[b] <= 1'b0;
    repeat (16) @(posedge clk);
  endtask

  // one press per tick period starting at a settled point
  task automatic edit_field(input logic down);
    if ((edges % TICK_CYCLES) != SETTLE) begin
      next_point();
    end
    press(down ? BTN_DEC : BTN_INC);
    model[cur_model] = step_field(cur_model, model[cur_model], down);
    @(negedge clk);
    compare_model();
  endtask

  task automatic move_cursor(input logic left);
    if ((edges % TICK_CYCLES) != SETTLE) begin
      next_point();
    end
    press(left ? BTN_LEFT : BTN_RIGHT);
    if (left) begin
      cur_model = (cur_model == NUM_FIELDS - 1) ? 0 : cur_model + 1;
    end else begin
      cur_model = (cur_model == 0) ? NUM_FIELDS - 1 : cur_model - 1;
    end
    @(negedge clk);
    compare_model();
  endtask

  task automatic glitch(input int len);
    @(posedge clk);
    btn[BTN_INC] <= 1'b1;
    repeat (len) @(posedge clk);
    btn[BTN_INC] <= 1'b0;
    repeat (8) @(posedge clk);
  endtask

  task automatic verify_reset();
    next_point();
    check("frame.marker[0]", frame.marker[0], 8'h11);
  endtask

  task automatic count_and_carry();
    repeat (61) next_point();
    check("datetime", datetime.bytes, 64'h0000_0101_0100_0101);
    // minute 01 down to 59 and then hour 00 down to 23
    move_cursor(1'b1);
    edit_field(1'b1);
    edit_field(1'b1);
    move_cursor(1'b1);
    edit_field(1'b1);
    wait_second(8'h59);
    check("hour minute second", datetime.bytes[2:0], 24'h23_59_59);
    next_point();
    check("date weekday time", datetime.bytes[4:0], 40'h02_02_00_00_00);
  endtask

  task automatic edit_with_wrap();
    move_cursor(1'b0);
    move_cursor(1'b0);
    wait_second(8'h09);
    edit_field(1'b0);
    check("second", datetime.f.second, 8'h10);
    wait_second(8'h59);
    edit_field(1'b0);
    check("second", datetime.f.second, field_min[0]);
    move_cursor(1'b1);
    move_cursor(1'b1);
    check("hour", datetime.f.hour, field_min[2]);
    edit_field(1'b1);
    check("hour", datetime.f.hour, field_max[2]);
    move_cursor(1'b1);
    move_cursor(1'b1);
    edit_field(1'b1);
    check("date", datetime.f.date, field_min[4]);
    edit_field(1'b1);
    check("date", datetime.f.date, field_max[4]);
  endtask

  task automatic move_cursor_wrap();
    move_cursor(1'b1);
    move_cursor(1'b1);
    move_cursor(1'b1);
    check("cursor", cursor, 0);
    move_cursor(1'b0);
    check("cursor", cursor, NUM_FIELDS - 1);
  endtask

  // glitches shorter than the debounce window must not edit
  task automatic filter_glitches();
    int len;
    repeat (4) begin
      next_point();
      repeat (3) begin
        draw_bits(3, len);
        glitch((len == 0) ? 1 : len);
      end
    end
    next_point();
  endtask

  initial begin
    rst       <= 1'b1;
    btn       <= '0;
    applied   = 0;
    cur_model = 0;
    // 00:00:00, weekday 01, date 01, month 01, year 00
    model     = 64'h0000_0101_0100_0000;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    verify_reset();
    count_and_carry();
    edit_with_wrap();
    move_cursor_wrap();
    filter_glitches();

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== rtc_console_top.f ====
common/rtc_pkg.sv
src/btn_debounce.sv
editor/bcd_step.sv
editor/rtc_edit_ctrl.sv
rtc/rtc_time_keeper.sv
src/display_frame.sv
src/rtc_console_top.sv
bench/rtc_console_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module rtc_console_tb \
  -f rtc_console_top.f -o rtc_console_sim || exit 1
out=$(./obj_dir/rtc_console_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
